// File: logic/eth_rx_pkg.sv
package eth_rx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word format

	// One MAC word per FIFO entry
	localparam int rx_data_width = 32;

	// Byte count of a word, 1 to 4, and 0 marks a frame delimiter
	localparam int rx_bytes_width = 3;

	// Bytes valid sits above the data in each FIFO word
	localparam int fifo_word_width = rx_bytes_width + rx_data_width;

	////////////////////////////////////////////////////////////////////////////
	// FIFO sizing

	// Room for at least two maximum-size frames
	localparam int fifo_depth = 1024;

	// Pointers carry one more bit than this for wrap detection
	localparam int fifo_addr_width = $clog2(fifo_depth);

	// Forwarded frame counter
	localparam int perf_count_width = 64;

	////////////////////////////////////////////////////////////////////////////
	// Pop FSM

	typedef enum logic [3:0] {
		idle          = 4'h0,
		wait_header_0 = 4'h1,
		wait_header_1 = 4'h2,
		wait_header_2 = 4'h3,
		wait_header_3 = 4'h4,
		packet_0      = 4'h5,
		packet_1      = 4'h6,
		packet_2      = 4'h7,
		packet_3      = 4'h8
	} rx_pop_state_t;

endpackage

// File: logic/gray_ptr_sync.sv
`timescale 1ns/10ps

module gray_ptr_sync #(
	parameter int ptr_width = 8
) (
	input  logic                 dst_clk,
	input  logic                 rst_n,
	input  logic [ptr_width-1:0] ptr_bin_src,
	output logic [ptr_width-1:0] ptr_bin_dst
);

	// Gray code of the source pointer
	logic [ptr_width-1:0] ptr_gray_src;

	// First and second destination flops
	logic [ptr_width-1:0] gray_meta;
	logic [ptr_width-1:0] gray_sync;

	assign ptr_gray_src = ptr_bin_src ^ (ptr_bin_src >> 1);

	always_ff @(posedge dst_clk or negedge rst_n) begin
		if (!rst_n) begin
			gray_meta <= '0;
			gray_sync <= '0;
		end else begin
			gray_meta <= ptr_gray_src;
			gray_sync <= gray_meta;
		end
	end

	// Gray back to binary, MSB down
	always_comb begin
		ptr_bin_dst[ptr_width-1] = gray_sync[ptr_width-1];
		for (int i = ptr_width - 2; i >= 0; i--) begin
			ptr_bin_dst[i] = ptr_bin_dst[i+1] ^ gray_sync[i];
		end
	end

	// Pointers only move forward, never by more than half the range per sample
	assert property (@(posedge dst_clk) disable iff (!rst_n)
		ptr_width'(ptr_bin_dst - $past(ptr_bin_dst)) <= (2 ** (ptr_width - 1)));

endmodule

// File: logic/cross_clock_packet_fifo.sv
`timescale 1ns/10ps

module cross_clock_packet_fifo
	import eth_rx_pkg::*;
(
	// Write port, MAC clock
	input  logic                       wr_clk,
	input  logic                       wr_en,
	input  logic [fifo_word_width-1:0] wr_data,
	input  logic                       wr_commit,
	input  logic                       wr_rollback,

	// Read port, system clock
	input  logic                       rd_clk,
	input  logic                       rd_en,
	input  logic [fifo_addr_width-1:0] rd_offset,
	input  logic                       rd_pop_packet,
	input  logic [fifo_addr_width:0]   rd_packet_size,
	output logic [fifo_word_width-1:0] rd_data,
	output logic [fifo_addr_width:0]   rd_size,

	input  logic                       rst_n
);

	// Dual-clock block memory
	logic [fifo_word_width-1:0] fifo_mem [fifo_depth];

	// Write side pointers, one wrap bit above the address
	logic [fifo_addr_width:0]   wr_ptr;
	logic [fifo_addr_width:0]   wr_ptr_committed;
	logic [fifo_addr_width:0]   rd_ptr_wr_sync;
	logic [fifo_addr_width:0]   wr_level;
	logic                       wr_full;
	logic                       wr_accept;
	logic                       wr_overflow;

	// Read side pointers
	logic [fifo_addr_width:0]   rd_ptr;
	logic [fifo_addr_width:0]   wr_ptr_rd_sync;
	logic [fifo_addr_width-1:0] rd_addr;

	// First output register stage
	logic [fifo_word_width-1:0] rd_stage;

	////////////////////////////////////////////////////////////////////////////
	// Pointer crossings

	// Committed write pointer into the read clock
	gray_ptr_sync #(
		.ptr_width(fifo_addr_width + 1)
	) wr_commit_sync_inst (
		.dst_clk(rd_clk),
		.rst_n(rst_n),
		.ptr_bin_src(wr_ptr_committed),
		.ptr_bin_dst(wr_ptr_rd_sync)
	);

	// Read pointer into the write clock, for the full check
	gray_ptr_sync #(
		.ptr_width(fifo_addr_width + 1)
	) rd_ptr_sync_inst (
		.dst_clk(wr_clk),
		.rst_n(rst_n),
		.ptr_bin_src(rd_ptr),
		.ptr_bin_dst(rd_ptr_wr_sync)
	);

	////////////////////////////////////////////////////////////////////////////
	// Write side

	// Level seen from the write side lags the reader, so full is conservative
	assign wr_level  = wr_ptr - rd_ptr_wr_sync;
	assign wr_full   = (wr_level == (fifo_addr_width + 1)'(fifo_depth));
	assign wr_accept = wr_en && !wr_full;

	always_ff @(posedge wr_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr           <= '0;
			wr_ptr_committed <= '0;
			wr_overflow      <= 1'b0;
		end else if (wr_commit) begin
			// Frame lost words to a full FIFO, throw it away
			if (wr_overflow) begin
				wr_ptr <= wr_ptr_committed;
			end else begin
				wr_ptr_committed <= wr_ptr;
			end
			wr_overflow <= 1'b0;
		end else if (wr_rollback) begin
			wr_ptr      <= wr_ptr_committed;
			wr_overflow <= 1'b0;
		end else if (wr_en) begin
			if (wr_full) begin
				wr_overflow <= 1'b1;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// Store at the tentative pointer
	always_ff @(posedge wr_clk) begin
		if (wr_accept) begin
			fifo_mem[wr_ptr[fifo_addr_width-1:0]] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side

	// Only committed frames count toward the size
	assign rd_size = wr_ptr_rd_sync - rd_ptr;

	// Offset reads wrap with the address
	assign rd_addr = rd_ptr[fifo_addr_width-1:0] + rd_offset;

	// Whole-packet pop
	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (rd_pop_packet) begin
			rd_ptr <= rd_ptr + rd_packet_size;
		end
	end

	// Two output stages, data lands two clocks after rd_en
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_stage <= fifo_mem[rd_addr];
		end
		rd_data <= rd_stage;
	end

	// Popper must never release words that are not committed yet
	assert property (@(posedge rd_clk) disable iff (!rst_n)
		rd_pop_packet |-> (rd_packet_size <= rd_size));

endmodule

// File: logic/eth_rx_clock_crossing.sv
`timescale 1ns/10ps

module eth_rx_clock_crossing
	import eth_rx_pkg::*;
(
	// MAC receive bus
	input  logic                        gmii_rxc,
	input  logic                        mac_rx_start,
	input  logic                        mac_rx_data_valid,
	input  logic [rx_bytes_width-1:0]   mac_rx_bytes_valid,
	input  logic [rx_data_width-1:0]    mac_rx_data,
	input  logic                        mac_rx_commit,
	input  logic                        mac_rx_drop,

	input  logic                        sys_clk,
	input  logic                        rst_n,

	// FIFO write port
	output logic                        wr_en,
	output logic [fifo_word_width-1:0]  wr_data,
	output logic                        wr_commit,
	output logic                        wr_rollback,

	// FIFO read port
	output logic                        rd_en,
	output logic [fifo_addr_width-1:0]  rd_offset,
	output logic                        rd_pop_packet,
	output logic [fifo_addr_width:0]    rd_packet_size,
	input  logic [fifo_word_width-1:0]  rd_data,
	input  logic [fifo_addr_width:0]    rd_size,

	// Downstream frame bus
	output logic                        cdc_rx_start,
	output logic                        cdc_rx_data_valid,
	output logic [rx_bytes_width-1:0]   cdc_rx_bytes_valid,
	output logic [rx_data_width-1:0]    cdc_rx_data,
	output logic                        cdc_rx_commit,

	output logic [perf_count_width-1:0] perf_rx_cdc_frames
);

	// Fields of the word coming out of the FIFO
	logic [rx_bytes_width-1:0]  rd_bytes_valid;
	logic [rx_data_width-1:0]   rd_word;

	rx_pop_state_t              pop_state;

	// Registered "a whole frame is waiting"
	logic                       has_packet;

	logic [fifo_addr_width:0]   offset_ext;
	logic                       fifo_dry;

	////////////////////////////////////////////////////////////////////////////
	// Push side

	// Start writes the zero delimiter and data cycles write bytes valid and data
	always_comb begin
		if (mac_rx_start) begin
			wr_en   = 1'b1;
			wr_data = '0;
		end else begin
			wr_en   = mac_rx_data_valid;
			wr_data = {mac_rx_bytes_valid, mac_rx_data};
		end
	end

	assign wr_commit   = mac_rx_commit;
	assign wr_rollback = mac_rx_drop;

	// A short word ends the frame, so no data may follow it
	assert property (@(posedge gmii_rxc) disable iff (!rst_n)
		(mac_rx_data_valid && (mac_rx_bytes_valid != rx_bytes_width'(4)))
		|=> !mac_rx_data_valid);

	////////////////////////////////////////////////////////////////////////////
	// Pop side

	assign {rd_bytes_valid, rd_word} = rd_data;

	// rd_data is two reads behind rd_offset
	// Dry once the word on rd_data is the last committed one
	assign offset_ext = {1'b0, rd_offset};
	assign fifo_dry   = (offset_ext >= (rd_size + 1'b1));

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			pop_state          <= wait_header_0;
			has_packet         <= 1'b0;
			rd_en              <= 1'b0;
			rd_offset          <= '0;
			rd_pop_packet      <= 1'b0;
			rd_packet_size     <= '0;
			cdc_rx_start       <= 1'b0;
			cdc_rx_data_valid  <= 1'b0;
			cdc_rx_commit      <= 1'b0;
			perf_rx_cdc_frames <= '0;
		end else begin
			rd_en         <= 1'b0;
			rd_pop_packet <= 1'b0;
			cdc_rx_start  <= 1'b0;
			cdc_rx_commit <= 1'b0;

			// Every non-delimiter word seen in packet_2 goes downstream
			cdc_rx_data_valid <= (pop_state == packet_2) && (rd_bytes_valid != '0);

			// Size is stale for a cycle after a pop
			has_packet <= (rd_size > 2) && !rd_pop_packet;

			case (pop_state)

				// Read offset 0 and check for the delimiter
				wait_header_0: begin
					if (!rd_pop_packet && has_packet) begin
						rd_en     <= 1'b1;
						rd_offset <= '0;
						pop_state <= wait_header_1;
					end
				end

				wait_header_1: begin
					pop_state <= wait_header_2;
				end

				wait_header_2: begin
					pop_state <= wait_header_3;
				end

				wait_header_3: begin
					if (rd_data == '0) begin
						pop_state <= idle;
					end else begin
						// Drop a non-delimiter word and look again
						rd_pop_packet  <= 1'b1;
						rd_packet_size <= (fifo_addr_width + 1)'(1);
						pop_state      <= wait_header_0;
					end
				end

				// Wait behind the checked delimiter for a whole frame
				idle: begin
					if (has_packet) begin
						cdc_rx_start <= 1'b1;
						rd_en        <= 1'b1;
						rd_offset    <= (fifo_addr_width)'(1);
						pop_state    <= packet_0;
					end
				end

				// Two reads in flight before the first word arrives
				packet_0: begin
					rd_en     <= 1'b1;
					rd_offset <= rd_offset + 1'b1;
					pop_state <= packet_1;
				end

				packet_1: begin
					rd_en     <= 1'b1;
					rd_offset <= rd_offset + 1'b1;
					pop_state <= packet_2;
				end

				// One word per clock until the frame ends
				packet_2: begin
					if (rd_bytes_valid == '0) begin
						// Next frame's delimiter means the frame ended on the word before
						rd_offset <= rd_offset - 2'd2;
						pop_state <= packet_3;
					end else if ((rd_bytes_valid != rx_bytes_width'(4)) || fifo_dry) begin
						// Short word or last committed word
						rd_offset <= rd_offset - 1'b1;
						pop_state <= packet_3;
					end else begin
						rd_en     <= 1'b1;
						rd_offset <= rd_offset + 1'b1;
					end
				end

				// Offset now holds delimiter plus data words
				packet_3: begin
					rd_pop_packet <= 1'b1;
					if (offset_ext >= rd_size) begin
						rd_packet_size <= rd_size;
					end else begin
						rd_packet_size <= offset_ext;
					end
					cdc_rx_commit      <= 1'b1;
					perf_rx_cdc_frames <= perf_rx_cdc_frames + 1'b1;
					pop_state          <= wait_header_0;
				end

				default: begin
					pop_state <= wait_header_0;
				end

			endcase
		end
	end

	// Word pipeline to downstream
	always_ff @(posedge sys_clk) begin
		cdc_rx_bytes_valid <= rd_bytes_valid;
		cdc_rx_data        <= rd_word;
	end

	// Idle holds the delimiter from offset 0 on the read bus with no data leaving
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		(pop_state == idle) |-> ((rd_data == '0) && !cdc_rx_data_valid));

endmodule

// File: logic/eth_rx_cdc_top.sv
`timescale 1ns/10ps

module eth_rx_cdc_top
	import eth_rx_pkg::*;
(
	// MAC side
	input  logic                        gmii_rxc,
	input  logic                        mac_rx_start,
	input  logic                        mac_rx_data_valid,
	input  logic [rx_bytes_width-1:0]   mac_rx_bytes_valid,
	input  logic [rx_data_width-1:0]    mac_rx_data,
	input  logic                        mac_rx_commit,
	input  logic                        mac_rx_drop,

	input  logic                        sys_clk,
	input  logic                        rst_n,

	// System side
	output logic                        cdc_rx_start,
	output logic                        cdc_rx_data_valid,
	output logic [rx_bytes_width-1:0]   cdc_rx_bytes_valid,
	output logic [rx_data_width-1:0]    cdc_rx_data,
	output logic                        cdc_rx_commit,
	output logic [perf_count_width-1:0] perf_rx_cdc_frames
);

	// Crossing to FIFO
	logic                       wr_en;
	logic [fifo_word_width-1:0] wr_data;
	logic                       wr_commit;
	logic                       wr_rollback;
	logic                       rd_en;
	logic [fifo_addr_width-1:0] rd_offset;
	logic                       rd_pop_packet;
	logic [fifo_addr_width:0]   rd_packet_size;
	logic [fifo_word_width-1:0] rd_data;
	logic [fifo_addr_width:0]   rd_size;

	// Framing and pop FSM, port names match the local wires
	eth_rx_clock_crossing eth_rx_clock_crossing_inst (.*);

	// Packet storage between the two clocks
	cross_clock_packet_fifo cross_clock_packet_fifo_inst (
		.wr_clk(gmii_rxc),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.wr_commit(wr_commit),
		.wr_rollback(wr_rollback),
		.rd_clk(sys_clk),
		.rd_en(rd_en),
		.rd_offset(rd_offset),
		.rd_pop_packet(rd_pop_packet),
		.rd_packet_size(rd_packet_size),
		.rd_data(rd_data),
		.rd_size(rd_size),
		.rst_n(rst_n)
	);

endmodule

// File: test/eth_rx_frame_model.sv
`timescale 1ns/10ps

module eth_rx_frame_model
	import eth_rx_pkg::*;
(
	input  logic                      sys_clk,
	input  logic                      rst_n,
	input  logic                      cdc_rx_start,
	input  logic                      cdc_rx_data_valid,
	input  logic [rx_bytes_width-1:0] cdc_rx_bytes_valid,
	input  logic [rx_data_width-1:0]  cdc_rx_data,
	input  logic                      cdc_rx_commit,
	output logic                      error_seen
);

	// Words of all committed frames in arrival order, bytes valid on top
	logic [fifo_word_width-1:0] exp_words[$];
	// Length of each committed frame
	int                         exp_lens[$];
	int                         frames_pushed = 0;
	int                         words_left = 0;
	logic                       in_frame = 1'b0;

	initial error_seen = 1'b0;

	task automatic push_word(input logic [fifo_word_width-1:0] word);
		exp_words.push_back(word);
	endtask

	task automatic push_frame_end(input int n_words);
		exp_lens.push_back(n_words);
		frames_pushed++;
	endtask

	// Frames committed but not yet closed downstream
	function automatic int frames_pending();
		return exp_lens.size() + (in_frame ? 1 : 0);
	endfunction

	task automatic flag_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		error_seen = 1'b1;
	endtask

	task automatic flag_protocol_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_seen = 1'b1;
	endtask

	task automatic check_word(input logic [rx_bytes_width-1:0] bv,
		input logic [rx_data_width-1:0] data);
		logic [fifo_word_width-1:0] expected;
		if (words_left == 0 || exp_words.size() == 0) begin
			flag_mismatch($sformatf("extra word bv %0d data %08h past frame end", bv, data));
		end else begin
			expected = exp_words.pop_front();
			words_left--;
			if ({bv, data} !== expected) begin
				flag_mismatch($sformatf("got bv %0d data %08h, expected bv %0d data %08h",
					bv, data, expected[fifo_word_width-1 -: rx_bytes_width],
					expected[rx_data_width-1:0]));
			end
		end
	endtask

	task automatic check_frame_end();
		if (!in_frame) begin
			flag_protocol_error("commit pulse without a frame start");
		end else if (words_left != 0) begin
			flag_mismatch($sformatf("frame closed with %0d words still missing", words_left));
		end
		in_frame = 1'b0;
	endtask

	task automatic check_count(input logic [perf_count_width-1:0] count);
		if (count !== perf_count_width'(frames_pushed)) begin
			flag_mismatch($sformatf("frame counter %0d, expected %0d", count, frames_pushed));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor, one look per system clock

	always @(posedge sys_clk) begin
		if (!error_seen) begin
			if (!rst_n) begin
				// Strobes must sit low through reset
				if (cdc_rx_start !== 1'b0 || cdc_rx_data_valid !== 1'b0 ||
					cdc_rx_commit !== 1'b0) begin
					flag_protocol_error("frame strobe active during reset");
				end
			end else begin
				if (cdc_rx_data_valid === 1'b1) begin
					if (!in_frame) begin
						flag_protocol_error("data word outside a start to commit bracket");
					end else begin
						check_word(cdc_rx_bytes_valid, cdc_rx_data);
					end
				end
				if (cdc_rx_commit === 1'b1) begin
					check_frame_end();
				end
				if (cdc_rx_start === 1'b1) begin
					if (in_frame) begin
						flag_protocol_error("second start pulse before the commit");
					end else if (exp_lens.size() == 0) begin
						flag_protocol_error("frame appeared that was never committed");
					end else begin
						in_frame   = 1'b1;
						words_left = exp_lens.pop_front();
					end
				end
			end
		end
	end

endmodule

// File: test/eth_rx_cdc_tb.sv
`timescale 1ns/10ps

module eth_rx_cdc_tb
	import eth_rx_pkg::*;
();

	// Test lengths also size the watchdog
	localparam int random_frames   = 24;
	localparam int burst_frames    = 16;
	localparam int max_frame_words = 64;
	localparam int overflow_words  = 1100;
	// Start, commit and up to eight idle cycles around each frame
	localparam int stim_words = (random_frames + burst_frames + 3) * (max_frame_words + 10)
		+ overflow_words;

	logic                        sys_clk;
	logic                        gmii_rxc;
	logic                        rst_n;
	logic                        mac_rx_start;
	logic                        mac_rx_data_valid;
	logic [rx_bytes_width-1:0]   mac_rx_bytes_valid;
	logic [rx_data_width-1:0]    mac_rx_data;
	logic                        mac_rx_commit;
	logic                        mac_rx_drop;
	logic                        cdc_rx_start;
	logic                        cdc_rx_data_valid;
	logic [rx_bytes_width-1:0]   cdc_rx_bytes_valid;
	logic [rx_data_width-1:0]    cdc_rx_data;
	logic                        cdc_rx_commit;
	logic [perf_count_width-1:0] perf_rx_cdc_frames;
	logic                        check_failed;

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	initial begin
		gmii_rxc = 1'b0;
		forever #5 gmii_rxc = ~gmii_rxc;
	end

	eth_rx_cdc_top eth_rx_cdc_top_inst (.*);

	eth_rx_frame_model frame_model_inst (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.cdc_rx_start(cdc_rx_start),
		.cdc_rx_data_valid(cdc_rx_data_valid),
		.cdc_rx_bytes_valid(cdc_rx_bytes_valid),
		.cdc_rx_data(cdc_rx_data),
		.cdc_rx_commit(cdc_rx_commit),
		.error_seen(check_failed)
	);

	////////////////////////////////////////////////////////////////////////////
	// MAC side stimulus

	// Start, full words, a short or full last word, then commit or drop
	task automatic send_frame(input int n_words, input bit drop, input int gap);
		logic [fifo_word_width-1:0] words[$];
		logic [rx_bytes_width-1:0]  bv;
		logic [rx_data_width-1:0]   data;
		@(posedge gmii_rxc);
		mac_rx_start <= 1'b1;
		for (int i = 0; i < n_words; i++) begin
			bv = (i == n_words - 1) ? rx_bytes_width'(1 + ($urandom % 4)) : rx_bytes_width'(4);
			data = $urandom;
			words.push_back({bv, data});
			@(posedge gmii_rxc);
			mac_rx_start       <= 1'b0;
			mac_rx_data_valid  <= 1'b1;
			mac_rx_bytes_valid <= bv;
			mac_rx_data        <= data;
		end
		@(posedge gmii_rxc);
		mac_rx_data_valid <= 1'b0;
		mac_rx_drop       <= drop;
		mac_rx_commit     <= !drop;
		// Only committed frames that fit in the FIFO come out
		if (!drop && (n_words + 1 <= fifo_depth)) begin
			foreach (words[i]) begin
				frame_model_inst.push_word(words[i]);
			end
			frame_model_inst.push_frame_end(n_words);
		end
		@(posedge gmii_rxc);
		mac_rx_commit <= 1'b0;
		mac_rx_drop   <= 1'b0;
		repeat (gap - 1) @(posedge gmii_rxc);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(32'h7e99));
		rst_n              <= 1'b0;
		mac_rx_start       <= 1'b0;
		mac_rx_data_valid  <= 1'b0;
		mac_rx_bytes_valid <= '0;
		mac_rx_data        <= '0;
		mac_rx_commit      <= 1'b0;
		mac_rx_drop        <= 1'b0;
		repeat (16) @(posedge sys_clk);
		rst_n <= 1'b1;
		// Nothing may come out of an idle bus
		repeat (40) @(posedge sys_clk);

		// Random lengths and gaps with about one frame in five dropped
		for (int f = 0; f < random_frames; f++) begin
			send_frame(2 + ($urandom % (max_frame_words - 1)), ($urandom % 5) == 0,
				1 + ($urandom % 8));
		end

		// Oversized frame and a dropped one between two good frames
		send_frame(overflow_words, 1'b0, 4);
		send_frame(2 + ($urandom % (max_frame_words - 1)), 1'b1, 1);
		send_frame(2 + ($urandom % (max_frame_words - 1)), 1'b0, 1);

		// Back to back with one idle cycle
		for (int f = 0; f < burst_frames; f++) begin
			send_frame(2 + ($urandom % (max_frame_words - 1)), 1'b0, 1);
		end

		while (frame_model_inst.frames_pending() != 0) @(posedge sys_clk);
		repeat (8) @(posedge sys_clk);
		frame_model_inst.check_count(perf_rx_cdc_frames);
		@(posedge sys_clk);
		if (check_failed) begin
			$display("Some tests failed");
			$fatal(1, "Checks failed");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

	// Stop at the first failed check
	always @(posedge check_failed) begin
		$display("Some tests failed");
		$fatal(1, "Stopped at the first failed check");
	end

	// Watchdog allows 200 ns per stimulus word plus 20 us
	initial begin
		#(stim_words * 200 + 20000);
		$display("Watchdog expired with frames still outstanding at %0t ns", $time);
		$display("Some tests failed");
		$fatal(1, "Run timed out");
	end

endmodule

// File: list.f
logic/eth_rx_pkg.sv
logic/gray_ptr_sync.sv
logic/cross_clock_packet_fifo.sv
logic/eth_rx_clock_crossing.sv
logic/eth_rx_cdc_top.sv
test/eth_rx_frame_model.sv
test/eth_rx_cdc_tb.sv
